//--- hw/bram_writer.sv
`timescale 1ns/100ps

module bram_writer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            x_valid,
    input  logic [capture_pkg::pix_w-1:0]   x_data,
    input  capture_pkg::ctrl_t              ctrl,
    output logic                            x_ready,
    output capture_pkg::stat_t              stat,
    output capture_pkg::wr_t                wr
);

    typedef enum logic [1:0] {
        st_idle,
        st_capturing,
        st_complete
    } state_t;

    state_t                             state;
    logic                               capturing;
    logic                               done;
    // Pixel count, the low bits double as the write address
    logic [capture_pkg::count_w-1:0]    pix_count;
    logic                               handshake;
    logic                               last_pixel;

    assign x_ready    = (state == st_capturing);
    assign handshake  = x_valid && x_ready;
    assign last_pixel = (pix_count == capture_pkg::count_w'(capture_pkg::total_pixels - 1));

    // Accepted pixel goes to the buffer on the same edge
    assign wr.en      = handshake;
    assign wr.addr    = pix_count[capture_pkg::pix_addr_w-1:0];
    assign wr.bit_val = (x_data >= ctrl.threshold);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            capturing <= 1'b0;
            done      <= 1'b0;
            pix_count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (ctrl.start) begin
                        state     <= st_capturing;
                        capturing <= 1'b1;
                        done      <= 1'b0;
                        pix_count <= '0;
                    end
                end

                st_capturing: begin
                    // Start here is ignored
                    if (handshake) begin
                        pix_count <= pix_count + 1'b1;
                        if (last_pixel) begin
                            state <= st_complete;
                        end
                    end
                end

                st_complete: begin
                    capturing <= 1'b0;
                    done      <= 1'b1;
                    state     <= st_idle;
                end

                default: state <= st_idle;
            endcase
        end
    end

    assign stat.capturing = capturing;
    assign stat.done      = done;
    assign stat.pix_count = pix_count;

endmodule

//--- hw/capture_pkg.sv
package capture_pkg;

    // Frame geometry
    localparam int img_width    = 16;
    localparam int img_height   = 4;
    localparam int total_pixels = img_width * img_height;
    localparam int pix_addr_w   = $clog2(total_pixels);

    // Readback word layout
    localparam int word_w      = 32;
    localparam int frame_words = total_pixels / word_w;
    localparam int word_addr_w = 1;

    // Bus and stream widths
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;
    localparam int pix_w      = 8;
    localparam int count_w    = pix_addr_w + 1;

    // Register map
    localparam logic [apb_addr_w-1:0] reg_ctrl       = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_status     = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_thresh     = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_frame_base = 8'h10;

    // Threshold after reset, only full white binarizes to one
    localparam logic [pix_w-1:0] thresh_reset = 8'hff;

    // Decode to capture engine
    typedef struct packed {
        logic             start;
        logic [pix_w-1:0] threshold;
    } ctrl_t;

    // Capture engine back to decode
    typedef struct packed {
        logic               capturing;
        logic               done;
        logic [count_w-1:0] pix_count;
    } stat_t;

    // One-bit write port into the frame buffer
    typedef struct packed {
        logic                  en;
        logic [pix_addr_w-1:0] addr;
        logic                  bit_val;
    } wr_t;

endpackage

//--- hw/capture_regs.sv
`timescale 1ns/100ps

module capture_regs (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [capture_pkg::apb_addr_w-1:0]      paddr,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [capture_pkg::apb_data_w-1:0]      pwdata,
    input  capture_pkg::stat_t                      stat,
    input  logic [capture_pkg::word_w-1:0]          rd_word,
    output logic [capture_pkg::apb_data_w-1:0]      prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output capture_pkg::ctrl_t                      ctrl,
    output logic [capture_pkg::word_addr_w-1:0]     rd_index
);

    logic [capture_pkg::pix_w-1:0]      thresh_q;
    logic                               wait_q;
    logic                               access;
    logic                               wr_access;
    logic                               rd_access;
    logic                               in_frame;
    logic                               frame_rd;
    logic [capture_pkg::apb_addr_w-1:0] frame_off;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;

    // Frame window covers frame_words consecutive words
    assign frame_off = paddr - capture_pkg::reg_frame_base;
    assign in_frame  = (paddr >= capture_pkg::reg_frame_base) &&
                       (frame_off < capture_pkg::apb_addr_w'(capture_pkg::frame_words * 4));
    assign frame_rd  = rd_access && in_frame;

    // Word index follows paddr, so the buffer read is launched in setup
    assign rd_index = frame_off[2 +: capture_pkg::word_addr_w];

    // Start is a single pulse in the access cycle of the ctrl write
    assign ctrl.start     = wr_access && (paddr == capture_pkg::reg_ctrl) && pwdata[0];
    assign ctrl.threshold = thresh_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            thresh_q <= capture_pkg::thresh_reset;
        end else if (wr_access && (paddr == capture_pkg::reg_thresh)) begin
            thresh_q <= pwdata[capture_pkg::pix_w-1:0];
        end
    end

    // One wait state on frame reads, rd_word is registered in the buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= frame_rd && !wait_q;
        end
    end

    always_comb begin
        if (frame_rd) begin
            pready = wait_q;
        end else begin
            pready = access;
        end
    end

    // Read data mux, unmapped addresses and ctrl read as zero
    always_comb begin
        prdata = '0;
        if (rd_access) begin
            if (in_frame) begin
                if (wait_q) begin
                    prdata = rd_word;
                end
            end else if (paddr == capture_pkg::reg_status) begin
                prdata[0]    = stat.capturing;
                prdata[1]    = stat.done;
                prdata[14:8] = stat.pix_count;
            end else if (paddr == capture_pkg::reg_thresh) begin
                prdata[capture_pkg::pix_w-1:0] = thresh_q;
            end
        end
    end

    // No error responses
    assign pslverr = 1'b0;

endmodule

//--- hw/capture_top.sv
`timescale 1ns/100ps

module capture_top (
    input  logic                                clk,
    input  logic                                rst_n,

    // APB slave
    input  logic [capture_pkg::apb_addr_w-1:0]  paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [capture_pkg::apb_data_w-1:0]  pwdata,
    output logic [capture_pkg::apb_data_w-1:0]  prdata,
    output logic                                pready,
    output logic                                pslverr,

    // Pixel stream
    input  logic                                x_valid,
    input  logic [capture_pkg::pix_w-1:0]       x_data,
    output logic                                x_ready
);

    capture_pkg::ctrl_t                     ctrl;
    capture_pkg::stat_t                     stat;
    capture_pkg::wr_t                       wr;
    logic [capture_pkg::word_addr_w-1:0]    rd_index;
    logic [capture_pkg::word_w-1:0]         rd_word;

    capture_regs i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .stat     (stat),
        .rd_word  (rd_word),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .ctrl     (ctrl),
        .rd_index (rd_index)
    );

    bram_writer i_writer (
        .clk     (clk),
        .rst_n   (rst_n),
        .x_valid (x_valid),
        .x_data  (x_data),
        .ctrl    (ctrl),
        .x_ready (x_ready),
        .stat    (stat),
        .wr      (wr)
    );

    frame_buffer i_buffer (
        .clk      (clk),
        .wr       (wr),
        .rd_index (rd_index),
        .rd_word  (rd_word)
    );

endmodule

//--- hw/frame_buffer.sv
`timescale 1ns/100ps

module frame_buffer (
    input  logic                                clk,
    input  capture_pkg::wr_t                    wr,
    input  logic [capture_pkg::word_addr_w-1:0] rd_index,
    output logic [capture_pkg::word_w-1:0]      rd_word
);

    // One cell per pixel in raster order
    logic [capture_pkg::total_pixels-1:0] cells;
    logic [capture_pkg::pix_addr_w-1:0]   rd_base;

    always_ff @(posedge clk) begin
        if (wr.en) begin
            cells[wr.addr] <= wr.bit_val;
        end
    end

    // First pixel of the selected word
    assign rd_base = {rd_index, {(capture_pkg::pix_addr_w - capture_pkg::word_addr_w){1'b0}}};

    // Word i holds pixels 32i up to 32i+31 with the lowest pixel in bit 0
    always_ff @(posedge clk) begin
        rd_word <= cells[rd_base +: capture_pkg::word_w];
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the capture testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module capture_tb -f tb.f --Mdir obj_dir -o capture_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/capture_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
    echo "Simulation reported failures, see $log"
    exit 1
fi

echo "Simulation clean, see $log"
exit 0

//--- tb.f
hw/capture_pkg.sv
hw/capture_regs.sv
hw/bram_writer.sv
hw/frame_buffer.sv
hw/capture_top.sv
verification/capture_tb.sv

//--- verification/capture_patterns.txt
// Per record: threshold, 16 pixel words (pixel 4n+b in byte b, byte 0 in bits 7:0),
// then expected frame word 0 and word 1
000000ff
ffffffff 00000000 ff00ff00 00ff00ff
fefefeff ff7f80fe 0000ffff ffff0000
12345678 ffffffff 000000ff ff000000
00ff0000 0000ff00 fffffffe 7fffff80
c3815a0f 6e2481f0
00000080
80808080 7f7f7f7f 00ff7f80 817e8001
01020304 c0a09080 80000000 00000080
ffffffff 00000000 7f80807f 807f7f80
90706050 50607090 8080ff00 3f80c0e0
18f0a50f 7e18960f
00000001
00000000 01010101 00010001 01000100
10000000 00000020 00300000 00004000
ffffffff ff0000ff 00ffff00 00000000
0a0b0c0d 000e0f00 00000001 01000000
2418a5f0 816f069f

//--- verification/capture_tb.sv
`timescale 1ns/100ps

module capture_tb;

    // Each record holds the threshold, 16 pixel words and 2 expected frame words
    localparam int rec_words = 19;
    localparam int num_recs  = 3;

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        x_valid;
    logic [7:0]  x_data;
    logic        x_ready;

    logic [31:0] pats [0:num_recs*rec_words-1];
    integer      seed;
    int          errors;

    capture_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .x_valid (x_valid),
        .x_data  (x_data),
        .x_ready (x_ready)
    );

    always #4 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %08h, actual %08h", name, exp, act);
            errors++;
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waits;
        int exp_waits;
        // Only frame window reads take a wait state
        exp_waits = 0;
        if (!wr && addr >= capture_pkg::reg_frame_base &&
            addr < capture_pkg::reg_frame_base + 8'(capture_pkg::frame_words * 4)) begin
            exp_waits = 1;
        end
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        next_cycle();
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready && waits < 10) begin
            @(negedge clk);
            waits++;
        end
        rdata = prdata;
        if (!pready) begin
            $display("APB access to address %02h never saw pready", addr);
            errors++;
        end else begin
            check_val($sformatf("wait states at %02h", addr), exp_waits, waits);
        end
        check_val("pslverr", 32'h0, {31'h0, pslverr});
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(addr, 1'b1, data, unused);
    endtask

    task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        apb_access(addr, 1'b0, 32'h0, data);
        check_val(name, exp, data);
    endtask

    // Status has capturing in bit 0, done in bit 1 and the count in 15:8
    function automatic logic [31:0] status_word(input logic cap, input logic dn, input int count);
        logic [31:0] w;
        w       = '0;
        w[0]    = cap;
        w[1]    = dn;
        w[15:8] = 8'(count);
        return w;
    endfunction

    function automatic logic [7:0] pixel(input int rec, input int k);
        logic [31:0] w;
        w = pats[rec*rec_words + 1 + k/4];
        return w[8*(k%4) +: 8];
    endfunction

    task automatic mid_capture_checks(input int sent);
        x_valid = 1'b0;
        read_check("status mid capture", capture_pkg::reg_status, status_word(1'b1, 1'b0, sent));
        // Second start must not restart the count
        apb_write(capture_pkg::reg_ctrl, 32'h1);
        read_check("status after late start", capture_pkg::reg_status,
                   status_word(1'b1, 1'b0, sent));
    endtask

    task automatic stream_frame(input int rec);
        int   sent;
        int   cycles;
        logic take;
        sent   = 0;
        cycles = 0;
        while (sent < 64 && cycles < 1000) begin
            if (($random(seed) & 3) == 0) begin
                x_valid = 1'b0;
                x_data  = 8'($random(seed));
            end else begin
                x_valid = 1'b1;
                x_data  = pixel(rec, sent);
            end
            @(negedge clk);
            take = x_valid && x_ready;
            next_cycle();
            cycles++;
            if (take) begin
                sent++;
                if (sent == 20) begin
                    mid_capture_checks(sent);
                end
            end
        end
        x_valid = 1'b0;
        if (sent < 64) begin
            $display("Pixel stream stalled after %0d of 64 pixels", sent);
            errors++;
        end
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          polls;
        polls = 0;
        st    = '0;
        while (!st[1] && polls < 50) begin
            apb_access(capture_pkg::reg_status, 1'b0, 32'h0, st);
            polls++;
        end
        if (!st[1]) begin
            $display("Capture never reported done");
            errors++;
        end
    endtask

    task automatic run_capture(input int rec);
        int base;
        base = rec * rec_words;
        apb_write(capture_pkg::reg_thresh, pats[base]);
        apb_write(capture_pkg::reg_ctrl, 32'h1);
        // Start clears done and the count
        read_check($sformatf("status after start %0d", rec), capture_pkg::reg_status,
                   status_word(1'b1, 1'b0, 0));
        stream_frame(rec);
        wait_done();
        read_check($sformatf("status after done %0d", rec), capture_pkg::reg_status,
                   status_word(1'b0, 1'b1, 64));
        check_val("x_ready after done", 32'h0, {31'h0, x_ready});
        read_check($sformatf("frame %0d word 0", rec), capture_pkg::reg_frame_base, pats[base+17]);
        read_check($sformatf("frame %0d word 1", rec), capture_pkg::reg_frame_base + 8'h04,
                   pats[base+18]);
    endtask

    task automatic offer_while_idle();
        repeat (8) begin
            // Dark pixels would clear bit 0 if they were stored
            x_valid = 1'b1;
            x_data  = 8'h00;
            @(negedge clk);
            check_val("x_ready while idle", 32'h0, {31'h0, x_ready});
            next_cycle();
        end
        x_valid = 1'b0;
        read_check("status after idle offers", capture_pkg::reg_status,
                   status_word(1'b0, 1'b1, 64));
    endtask

    initial begin
        seed    = 32'h2713cc89;
        errors  = 0;
        clk     = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        x_valid = 1'b0;
        x_data  = '0;
        $readmemh("verification/capture_patterns.txt", pats);
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_val("x_ready after reset", 32'h0, {31'h0, x_ready});
        check_val("pready after reset", 32'h0, {31'h0, pready});
        read_check("status after reset", capture_pkg::reg_status, 32'h0);
        read_check("threshold after reset", capture_pkg::reg_thresh, 32'hff);
        read_check("undecoded 0x0c", 8'h0c, 32'h0);
        read_check("undecoded 0x40", 8'h40, 32'h0);

        apb_write(capture_pkg::reg_thresh, 32'h0000_005a);
        read_check("threshold readback", capture_pkg::reg_thresh, 32'h5a);
        apb_write(capture_pkg::reg_status, 32'hffff_ffff);
        read_check("status after write", capture_pkg::reg_status, 32'h0);

        for (int rec = 0; rec < num_recs; rec++) begin
            run_capture(rec);
            if (rec == 0) begin
                offer_while_idle();
                apb_write(capture_pkg::reg_frame_base, 32'h0);
                read_check("frame word after write", capture_pkg::reg_frame_base, pats[17]);
            end
        end

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
